//--- hw/gpio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// gpio shared definitions
// pin and bus widths, register offsets, event and level records and
// the packed apb request used between the top level and the registers
////////////////////////////////////////////////////////////////////////////

package gpio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // one bit per pin in every register
  localparam int GPIO_PINS      = 32;
  // byte address width seen on PADDR
  localparam int APB_AW         = 8;
  // edge records buffered between the synchronizer and the registers
  localparam int EVT_FIFO_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // register map, byte offsets of 32-bit words
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [APB_AW-1:0] {
    reg_input_val  = 8'h00,
    reg_input_en   = 8'h04,
    reg_output_en  = 8'h08,
    reg_output_val = 8'h0C,
    reg_rise_ie    = 8'h18,
    reg_rise_ip    = 8'h1C,
    reg_fall_ie    = 8'h20,
    reg_fall_ip    = 8'h24,
    reg_high_ie    = 8'h28,
    reg_high_ip    = 8'h2C,
    reg_low_ie     = 8'h30,
    reg_low_ip     = 8'h34,
    reg_iof_en     = 8'h38,
    reg_iof_sel    = 8'h3C,
    reg_out_xor    = 8'h40
  } gpio_reg_e;

  ////////////////////////////////////////////////////////////////////////////
  // records
  ////////////////////////////////////////////////////////////////////////////

  // pin vector
  typedef logic [GPIO_PINS-1:0] gpio_word_t;

  // one edge record, bits may collect several edges while held
  typedef struct packed {
    gpio_word_t rise;
    gpio_word_t fall;
  } gpio_event_t;

  // level path, sampled is already masked at the sync input
  typedef struct packed {
    gpio_word_t sampled;
    gpio_word_t enabled;
  } gpio_level_t;

  // apb request as seen by the register block
  typedef struct packed {
    logic              sel;
    logic              enable;
    logic              write;
    logic [APB_AW-1:0] addr;
    logic [31:0]       wdata;
  } apb_req_t;

endpackage

//--- hw/gpio_input_sync.sv
////////////////////////////////////////////////////////////////////////////
// gpio input synchronizer and edge detector
// three-flop sync of the masked pins, edge records merged under
// back-pressure so that no edge is lost
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gpio_input_sync (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  gpio_pkg::gpio_word_t  pins_in,
  input  gpio_pkg::gpio_word_t  input_en,
  output gpio_pkg::gpio_level_t level,
  output gpio_pkg::gpio_event_t evt,
  output logic                  evt_valid,
  input  logic                  evt_ready
);
  import gpio_pkg::*;

  // synchronizer stages
  gpio_word_t  sync1;
  gpio_word_t  sync2;
  gpio_word_t  sync3;

  // edges seen this cycle and the record waiting for the fifo
  gpio_event_t new_evt;
  gpio_event_t hold_evt;
  logic        hold_valid;
  logic        new_any;
  logic        accept;

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // pins masked before the first stage, a disabled pin reads low
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync1 <= '0;
      sync2 <= '0;
      sync3 <= '0;
    end else begin
      sync1 <= pins_in & input_en;
      sync2 <= sync1;
      sync3 <= sync2;
    end
  end

  assign level.sampled = sync3;
  assign level.enabled = input_en;

  ////////////////////////////////////////////////////////////////////////////
  // edge records
  ////////////////////////////////////////////////////////////////////////////

  // stage 2 is the newer value, stage 3 the older
  assign new_evt.rise = sync2 & ~sync3;
  assign new_evt.fall = ~sync2 & sync3;
  assign new_any      = |new_evt;

  assign accept = hold_valid & evt_ready;

  // on accept the edges of this cycle open a fresh record,
  // otherwise they are ORed into the held one
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      hold_evt   <= '0;
      hold_valid <= 1'b0;
    end else if (accept || !hold_valid) begin
      hold_evt   <= new_evt;
      hold_valid <= new_any;
    end else begin
      hold_evt   <= hold_evt | new_evt;
      hold_valid <= 1'b1;
    end
  end

  assign evt       = hold_evt;
  assign evt_valid = hold_valid;

  // a stalled record stays valid and only gains bits
  a_evt_hold: assert property (@(posedge PCLK) disable iff (!PRESETn)
    evt_valid && !evt_ready |=> evt_valid && ((evt | $past(evt)) == evt))
    else $error("edge record dropped or lost bits while stalled");

endmodule

//--- hw/gpio_event_fifo.sv
////////////////////////////////////////////////////////////////////////////
// gpio event fifo
// small synchronous circular buffer of edge records, valid/ready on both
// sides, read data taken straight from the storage array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gpio_event_fifo #(
  parameter int DEPTH = gpio_pkg::EVT_FIFO_DEPTH
) (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  gpio_pkg::gpio_event_t in_evt,
  input  logic                  in_valid,
  output logic                  in_ready,
  output gpio_pkg::gpio_event_t out_evt,
  output logic                  out_valid,
  input  logic                  out_ready
);
  import gpio_pkg::*;

  // pointer width, DEPTH is a power of two
  localparam int AW = $clog2(DEPTH);

  gpio_event_t   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // one bit wider than the pointers so that full is representable
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  ////////////////////////////////////////////////////////////////////////////
  // status and handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign in_ready  = (count != (AW+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // head of queue, visible the cycle after it was written
  assign out_evt = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (push) begin
      mem[wr_ptr] <= in_evt;
    end
  end

  // pointers wrap naturally at DEPTH
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a push while full would carry the count past DEPTH
  a_no_overflow: assert property (@(posedge PCLK) disable iff (!PRESETn)
    count <= (AW+1)'(DEPTH))
    else $error("event fifo written while full");

  // from empty only a push may follow, a pop would wrap the count
  a_no_underflow: assert property (@(posedge PCLK) disable iff (!PRESETn)
    count == '0 |=> count <= (AW+1)'(1))
    else $error("event fifo read while empty");

endmodule

//--- hw/gpio_apb_regs.sv
////////////////////////////////////////////////////////////////////////////
// gpio apb register block
// control and pending registers, pin output muxing and interrupt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gpio_apb_regs (
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  gpio_pkg::apb_req_t    req,
  output gpio_pkg::gpio_word_t  prdata,
  input  gpio_pkg::gpio_level_t level,
  input  gpio_pkg::gpio_event_t q_evt,
  input  logic                  q_valid,
  output logic                  q_ready,
  output gpio_pkg::gpio_word_t  input_en,
  input  gpio_pkg::gpio_word_t  iof0,
  input  gpio_pkg::gpio_word_t  iof1,
  output gpio_pkg::gpio_word_t  pins_out,
  output gpio_pkg::gpio_word_t  pins_oe,
  output logic                  irq
);
  import gpio_pkg::*;

  // decoded word offset
  gpio_reg_e  reg_sel;
  logic       wr_en;

  // control registers
  gpio_word_t output_en;
  gpio_word_t output_val;
  gpio_word_t rise_ie;
  gpio_word_t fall_ie;
  gpio_word_t high_ie;
  gpio_word_t low_ie;
  gpio_word_t iof_en;
  gpio_word_t iof_sel;
  gpio_word_t out_xor;

  // pending registers, sticky until written with 1
  gpio_word_t rise_ip;
  gpio_word_t fall_ip;
  gpio_word_t high_ip;
  gpio_word_t low_ip;

  // write-one-to-clear strobes
  logic       clr_rise;
  logic       clr_fall;
  logic       clr_high;
  logic       clr_low;
  logic       ip_wr;
  logic       evt_take;

  // output path
  gpio_word_t iof_out;
  gpio_word_t gpio_out;

  ////////////////////////////////////////////////////////////////////////////
  // apb decode
  ////////////////////////////////////////////////////////////////////////////

  // word aligned, low address bits ignored
  assign reg_sel = gpio_reg_e'({req.addr[APB_AW-1:2], 2'b00});
  // writes land in the access phase
  assign wr_en   = req.sel & req.enable & req.write;

  assign clr_rise = wr_en && (reg_sel == reg_rise_ip);
  assign clr_fall = wr_en && (reg_sel == reg_fall_ip);
  assign clr_high = wr_en && (reg_sel == reg_high_ip);
  assign clr_low  = wr_en && (reg_sel == reg_low_ip);
  assign ip_wr    = clr_rise | clr_fall | clr_high | clr_low;

  // queue stalls while software touches a pending register,
  // so a clear never meets a set in the same cycle
  assign q_ready  = ~ip_wr;
  assign evt_take = q_valid & q_ready;

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      input_en   <= '0;
      output_en  <= '0;
      output_val <= '0;
      rise_ie    <= '0;
      fall_ie    <= '0;
      high_ie    <= '0;
      low_ie     <= '0;
      iof_en     <= '0;
      iof_sel    <= '0;
      out_xor    <= '0;
    end else if (wr_en) begin
      // input_val and the pending words are not plain storage
      case (reg_sel)
        reg_input_en:   input_en   <= req.wdata;
        reg_output_en:  output_en  <= req.wdata;
        reg_output_val: output_val <= req.wdata;
        reg_rise_ie:    rise_ie    <= req.wdata;
        reg_fall_ie:    fall_ie    <= req.wdata;
        reg_high_ie:    high_ie    <= req.wdata;
        reg_low_ie:     low_ie     <= req.wdata;
        reg_iof_en:     iof_en     <= req.wdata;
        reg_iof_sel:    iof_sel    <= req.wdata;
        reg_out_xor:    out_xor    <= req.wdata;
        default:        ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pending registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rise_ip <= '0;
      fall_ip <= '0;
      high_ip <= '0;
      low_ip  <= '0;
    end else begin
      // edges arrive as fifo records
      if (clr_rise) begin
        rise_ip <= rise_ip & ~req.wdata;
      end else if (evt_take) begin
        rise_ip <= rise_ip | q_evt.rise;
      end
      if (clr_fall) begin
        fall_ip <= fall_ip & ~req.wdata;
      end else if (evt_take) begin
        fall_ip <= fall_ip | q_evt.fall;
      end
      // levels every cycle
      // high is masked by the live enable so a pin just disabled
      // cannot raise it from stale sync stages
      if (clr_high) begin
        high_ip <= high_ip & ~req.wdata;
      end else begin
        high_ip <= high_ip | (level.sampled & level.enabled);
      end
      // a disabled pin reads low and keeps low set
      if (clr_low) begin
        low_ip <= low_ip & ~req.wdata;
      end else begin
        low_ip <= low_ip | ~level.sampled;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////////////////////

  // sampled on every edge, valid in the access phase
  always_ff @(posedge PCLK) begin
    case (reg_sel)
      reg_input_val:  prdata <= level.sampled;
      reg_input_en:   prdata <= input_en;
      reg_output_en:  prdata <= output_en;
      reg_output_val: prdata <= output_val;
      reg_rise_ie:    prdata <= rise_ie;
      reg_rise_ip:    prdata <= rise_ip;
      reg_fall_ie:    prdata <= fall_ie;
      reg_fall_ip:    prdata <= fall_ip;
      reg_high_ie:    prdata <= high_ie;
      reg_high_ip:    prdata <= high_ip;
      reg_low_ie:     prdata <= low_ie;
      reg_low_ip:     prdata <= low_ip;
      reg_iof_en:     prdata <= iof_en;
      reg_iof_sel:    prdata <= iof_sel;
      reg_out_xor:    prdata <= out_xor;
      default:        prdata <= '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // pins and interrupt
  ////////////////////////////////////////////////////////////////////////////

  // per bit, iof_sel chooses the function, iof_en chooses function or gpio
  assign iof_out  = (iof_sel & iof1) | (~iof_sel & iof0);
  assign gpio_out = (iof_en & iof_out) | (~iof_en & output_val);
  // polarity flip last
  assign pins_out = gpio_out ^ out_xor;
  assign pins_oe  = output_en;

  assign irq = |{rise_ip & rise_ie, fall_ip & fall_ie, high_ip & high_ie, low_ip & low_ie};

  // a record taken from the queue shows up in the pending bits one cycle later
  a_evt_lands: assert property (@(posedge PCLK) disable iff (!PRESETn)
    evt_take |=> ((rise_ip & $past(q_evt.rise)) == $past(q_evt.rise)) &&
                 ((fall_ip & $past(q_evt.fall)) == $past(q_evt.fall)))
    else $error("queued edge record lost behind a pending register write");

endmodule

//--- hw/gpio_apb_top.sv
////////////////////////////////////////////////////////////////////////////
// gpio apb top level
// synchronizer, event fifo and register block on a 32-bit apb port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gpio_apb_top (
  input  logic                         PCLK,
  input  logic                         PRESETn,
  input  logic                         PSEL,
  input  logic                         PENABLE,
  input  logic                         PWRITE,
  input  logic [gpio_pkg::APB_AW-1:0]  PADDR,
  input  logic [31:0]                  PWDATA,
  output logic [31:0]                  PRDATA,
  output logic                         PREADY,
  input  gpio_pkg::gpio_word_t         pins_in,
  input  gpio_pkg::gpio_word_t         iof0,
  input  gpio_pkg::gpio_word_t         iof1,
  output gpio_pkg::gpio_word_t         pins_out,
  output gpio_pkg::gpio_word_t         pins_oe,
  output logic                         irq
);
  import gpio_pkg::*;

  apb_req_t    req;
  gpio_word_t  input_en;
  gpio_level_t level;

  // producer side of the event queue
  gpio_event_t evt;
  logic        evt_valid;
  logic        evt_ready;

  // consumer side
  gpio_event_t q_evt;
  logic        q_valid;
  logic        q_ready;

  // apb request bundle
  assign req.sel    = PSEL;
  assign req.enable = PENABLE;
  assign req.write  = PWRITE;
  assign req.addr   = PADDR;
  assign req.wdata  = PWDATA;

  // no wait states
  assign PREADY = 1'b1;

  gpio_input_sync gpio_input_sync_i (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .pins_in   (pins_in),
    .input_en  (input_en),
    .level     (level),
    .evt       (evt),
    .evt_valid (evt_valid),
    .evt_ready (evt_ready)
  );

  gpio_event_fifo #(
    .DEPTH (EVT_FIFO_DEPTH)
  ) gpio_event_fifo_i (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .in_evt    (evt),
    .in_valid  (evt_valid),
    .in_ready  (evt_ready),
    .out_evt   (q_evt),
    .out_valid (q_valid),
    .out_ready (q_ready)
  );

  gpio_apb_regs gpio_apb_regs_i (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .req      (req),
    .prdata   (PRDATA),
    .level    (level),
    .q_evt    (q_evt),
    .q_valid  (q_valid),
    .q_ready  (q_ready),
    .input_en (input_en),
    .iof0     (iof0),
    .iof1     (iof1),
    .pins_out (pins_out),
    .pins_oe  (pins_oe),
    .irq      (irq)
  );

endmodule

//--- testbench/gpio_tb.sv
////////////////////////////////////////////////////////////////////////////
// gpio apb testbench
// table of apb accesses, pin stimulus and expected values run row by row
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gpio_tb;
  import gpio_pkg::*;

  // row kinds
  typedef enum logic [2:0] {
    op_write, op_read, op_poll, op_idle, op_pins, op_oe, op_irq, op_wr_pins
  } op_e;

  // one table row, wdata doubles as poll mask and idle cycle count
  // want doubles as the access phase pins of a toggling write
  typedef struct packed {
    op_e        op;
    gpio_reg_e  reg_addr;
    gpio_word_t wdata;
    gpio_word_t pins;
    gpio_word_t io0;
    gpio_word_t io1;
    gpio_word_t want;
  } row_t;

  logic              PCLK;
  logic              PRESETn;
  logic              PSEL;
  logic              PENABLE;
  logic              PWRITE;
  logic [APB_AW-1:0] PADDR;
  logic [31:0]       PWDATA;
  logic [31:0]       PRDATA;
  logic              PREADY;
  gpio_word_t        pins_in;
  gpio_word_t        iof0;
  gpio_word_t        iof1;
  gpio_word_t        pins_out;
  gpio_word_t        pins_oe;
  logic              irq;

  row_t       rows [$];
  // pin and iof state carried from row to row while the table is built
  gpio_word_t cur_pins;
  gpio_word_t cur_io0;
  gpio_word_t cur_io1;
  int         pass_count;
  int         fail_count;

  gpio_apb_top gpio_apb_top_i (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PRDATA   (PRDATA),
    .PREADY   (PREADY),
    .pins_in  (pins_in),
    .iof0     (iof0),
    .iof1     (iof1),
    .pins_out (pins_out),
    .pins_oe  (pins_oe),
    .irq      (irq)
  );

  initial begin
    PCLK = 1'b0;
    forever #50 PCLK = ~PCLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus and check tasks
  ////////////////////////////////////////////////////////////////////////////

  // entered on a falling edge, left on a falling edge with the bus idle
  task automatic write_reg(input gpio_reg_e addr, input gpio_word_t data);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    @(negedge PCLK);
    PENABLE = 1'b1;
    // no wait states, the write completes on the next rising edge
    check_bit("PREADY", PREADY, 1'b1);
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  // PRDATA is registered at the setup edge, stable mid access phase
  task automatic read_reg(input gpio_reg_e addr, output gpio_word_t data);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = addr;
    @(negedge PCLK);
    PENABLE = 1'b1;
    data    = PRDATA;
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic check_word(input string name, input gpio_word_t got, input gpio_word_t want);
    if (got === want) begin
      pass_count++;
      $display("ok %s = %h", name, got);
    end else begin
      fail_count++;
      $display("mismatch %s: got %h, expected %h", name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got === want) begin
      pass_count++;
      $display("ok %s = %h", name, got);
    end else begin
      fail_count++;
      $display("mismatch %s: got %h, expected %h", name, got, want);
    end
  endtask

  // read until the masked bits match, 50 cycles at most
  task automatic poll_reg(input gpio_reg_e addr, input gpio_word_t mask,
                          input gpio_word_t want);
    gpio_word_t got;
    int         cycles;
    logic       done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < 50) begin
      read_reg(addr, got);
      cycles += 2;
      done = ((got & mask) === want);
    end
    if (done) begin
      pass_count++;
      $display("ok poll %s = %h after %0d cycles", addr.name(), got, cycles);
    end else begin
      fail_count++;
      $display("timeout: %s never showed %h under mask %h within 50 cycles, last read %h",
               addr.name(), want, mask, got);
    end
  endtask

  // per pin, alternate function or gpio value, then the polarity flip
  function automatic gpio_word_t expected_pins_out(
    gpio_word_t oval, gpio_word_t en, gpio_word_t sel,
    gpio_word_t xr, gpio_word_t io0, gpio_word_t io1);
    gpio_word_t res;
    logic       fn;
    for (int i = 0; i < GPIO_PINS; i++) begin
      fn     = sel[i] ? io1[i] : io0[i];
      res[i] = (en[i] ? fn : oval[i]) ^ xr[i];
    end
    return res;
  endfunction

  task automatic run_row(input row_t r);
    gpio_word_t got;
    pins_in = r.pins;
    iof0    = r.io0;
    iof1    = r.io1;
    case (r.op)
      op_write: write_reg(r.reg_addr, r.wdata);
      op_wr_pins: begin
        // pins take their second value as the access phase opens
        fork
          write_reg(r.reg_addr, r.wdata);
          begin
            @(negedge PCLK);
            pins_in = r.want;
          end
        join
      end
      op_read: begin
        read_reg(r.reg_addr, got);
        check_word(r.reg_addr.name(), got, r.want);
      end
      op_poll: poll_reg(r.reg_addr, r.wdata, r.want);
      op_idle: repeat (r.wdata) @(negedge PCLK);
      op_pins: begin
        @(negedge PCLK);
        check_word("pins_out", pins_out, r.want);
      end
      op_oe: begin
        @(negedge PCLK);
        check_word("pins_oe", pins_oe, r.want);
      end
      default: begin
        @(negedge PCLK);
        check_bit("irq", irq, r.want[0]);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input op_e op, input gpio_reg_e addr,
                         input gpio_word_t wdata, input gpio_word_t want);
    row_t r;
    r.op       = op;
    r.reg_addr = addr;
    r.wdata    = wdata;
    r.pins     = cur_pins;
    r.io0      = cur_io0;
    r.io1      = cur_io1;
    r.want     = want;
    rows.push_back(r);
  endtask

  task automatic fill_table();
    gpio_reg_e  r;
    gpio_reg_e  ctrl [10];
    gpio_word_t ones;
    gpio_word_t v;
    gpio_word_t m;
    gpio_word_t p;
    gpio_word_t q;
    gpio_word_t prev;
    gpio_word_t rm;
    gpio_word_t fm;
    gpio_word_t oval;
    gpio_word_t en;
    gpio_word_t sel;
    gpio_word_t xr;
    gpio_word_t oe;
    int         i;
    ones = '1;
    ctrl = '{reg_input_en, reg_output_en, reg_output_val, reg_rise_ie, reg_fall_ie,
             reg_high_ie, reg_low_ie, reg_iof_en, reg_iof_sel, reg_out_xor};

    // reset state, low_ip fills at once since every pin reads low
    add_row(op_oe, reg_input_val, '0, '0);
    add_row(op_irq, reg_input_val, '0, '0);
    r = r.first();
    repeat (r.num()) begin
      add_row(op_read, r, '0, (r == reg_low_ip) ? ones : gpio_word_t'(0));
      r = r.next();
    end
    // control readback
    foreach (ctrl[k]) begin
      v = $urandom();
      add_row(op_write, ctrl[k], v, '0);
      add_row(op_read, ctrl[k], '0, v);
    end
    // input_val is read only, pins are still low
    add_row(op_write, reg_input_val, $urandom(), '0);
    add_row(op_read, reg_input_val, '0, '0);

    // output muxing
    for (i = 0; i < 4; i++) begin
      oval    = $urandom();
      en      = $urandom();
      sel     = $urandom();
      xr      = $urandom();
      oe      = $urandom();
      cur_io0 = $urandom();
      cur_io1 = $urandom();
      add_row(op_write, reg_output_val, oval, '0);
      add_row(op_write, reg_iof_en, en, '0);
      add_row(op_write, reg_iof_sel, sel, '0);
      add_row(op_write, reg_out_xor, xr, '0);
      add_row(op_write, reg_output_en, oe, '0);
      add_row(op_pins, reg_input_val, '0, expected_pins_out(oval, en, sel, xr, cur_io0, cur_io1));
      add_row(op_oe, reg_input_val, '0, oe);
    end

    // input path, interrupts off from here on
    add_row(op_write, reg_rise_ie, '0, '0);
    add_row(op_write, reg_fall_ie, '0, '0);
    add_row(op_write, reg_high_ie, '0, '0);
    add_row(op_write, reg_low_ie, '0, '0);
    add_row(op_irq, reg_input_val, '0, '0);
    for (i = 0; i < 4; i++) begin
      // last pass disables every pin
      m        = (i == 3) ? gpio_word_t'(0) : gpio_word_t'($urandom());
      cur_pins = $urandom();
      add_row(op_write, reg_input_en, m, '0);
      add_row(op_poll, reg_input_val, ones, cur_pins & m);
    end

    // edges on pins 5 and 9
    cur_pins = '0;
    add_row(op_write, reg_input_en, ones, '0);
    add_row(op_poll, reg_input_val, ones, '0);
    add_row(op_idle, reg_input_val, 10, '0);
    add_row(op_write, reg_rise_ip, ones, '0);
    add_row(op_write, reg_fall_ip, ones, '0);
    add_row(op_read, reg_rise_ip, '0, '0);
    add_row(op_read, reg_fall_ip, '0, '0);
    cur_pins = 32'h0000_0220;
    add_row(op_poll, reg_rise_ip, 32'h0000_0220, 32'h0000_0220);
    add_row(op_irq, reg_input_val, '0, '0);
    add_row(op_write, reg_rise_ie, 32'h0000_0020, '0);
    add_row(op_irq, reg_input_val, '0, 32'h1);
    add_row(op_write, reg_rise_ip, 32'h0000_0020, '0);
    add_row(op_read, reg_rise_ip, '0, 32'h0000_0200);
    add_row(op_irq, reg_input_val, '0, '0);
    // pin 9 falls, pin 5 stays high
    cur_pins = 32'h0000_0020;
    add_row(op_poll, reg_fall_ip, 32'h0000_0200, 32'h0000_0200);
    add_row(op_read, reg_fall_ip, '0, 32'h0000_0200);
    add_row(op_write, reg_fall_ie, 32'h0000_0200, '0);
    add_row(op_irq, reg_input_val, '0, 32'h1);
    add_row(op_write, reg_fall_ip, ones, '0);
    add_row(op_read, reg_fall_ip, '0, '0);
    add_row(op_irq, reg_input_val, '0, '0);
    add_row(op_write, reg_rise_ie, '0, '0);
    add_row(op_write, reg_fall_ie, '0, '0);

    // levels, pin 3 held high
    cur_pins = 32'h0000_0008;
    add_row(op_poll, reg_input_val, ones, 32'h0000_0008);
    add_row(op_write, reg_high_ip, ones, '0);
    add_row(op_poll, reg_high_ip, ones, 32'h0000_0008);
    add_row(op_write, reg_low_ip, ones, '0);
    add_row(op_poll, reg_low_ip, ones, ~32'h0000_0008);
    add_row(op_write, reg_high_ie, 32'h0000_0008, '0);
    add_row(op_irq, reg_input_val, '0, 32'h1);
    add_row(op_write, reg_high_ie, '0, '0);
    add_row(op_irq, reg_input_val, '0, '0);
    // disabled pins read low, so only low_ip comes back
    add_row(op_write, reg_input_en, '0, '0);
    add_row(op_poll, reg_input_val, ones, '0);
    add_row(op_write, reg_high_ip, ones, '0);
    add_row(op_write, reg_low_ip, ones, '0);
    add_row(op_poll, reg_low_ip, ones, ones);
    add_row(op_read, reg_high_ip, '0, '0);

    // back-pressure, pins change every cycle while pending writes stall the queue
    cur_pins = '0;
    add_row(op_write, reg_input_en, ones, '0);
    add_row(op_poll, reg_input_val, ones, '0);
    add_row(op_idle, reg_input_val, 10, '0);
    add_row(op_write, reg_rise_ip, ones, '0);
    add_row(op_write, reg_fall_ip, ones, '0);
    prev = '0;
    rm   = '0;
    fm   = '0;
    for (i = 0; i < 48; i++) begin
      // quiet at the end
      p    = (i == 47) ? gpio_word_t'(0) : gpio_word_t'($urandom());
      q    = (i == 47) ? gpio_word_t'(0) : gpio_word_t'($urandom());
      // setup phase pins then access phase pins
      rm   = rm | (p & ~prev) | (q & ~p);
      fm   = fm | (~p & prev) | (~q & p);
      prev = q;
      cur_pins = p;
      // writing 0 clears nothing but still stalls the queue
      add_row(op_wr_pins, (i % 2 == 0) ? reg_rise_ip : reg_fall_ip, '0, q);
    end
    add_row(op_poll, reg_rise_ip, rm, rm);
    add_row(op_poll, reg_fall_ip, fm, fm);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    PRESETn    = 1'b0;
    PSEL       = 1'b0;
    PENABLE    = 1'b0;
    PWRITE     = 1'b0;
    PADDR      = '0;
    PWDATA     = '0;
    pins_in    = '0;
    iof0       = '0;
    iof1       = '0;
    cur_pins   = '0;
    cur_io0    = '0;
    cur_io1    = '0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(13));
    fill_table();

    repeat (5) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;

    foreach (rows[k]) begin
      run_row(rows[k]);
    end

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
hw/gpio_pkg.sv
hw/gpio_input_sync.sv
hw/gpio_event_fifo.sv
hw/gpio_apb_regs.sv
hw/gpio_apb_top.sv
testbench/gpio_tb.sv
